// ==== filelist.f ====
+incdir+tb
hw/csr_pkg.sv
hw/csr_file.sv
hw/csr_counters.sv
hw/trap_unit.sv
hw/csr_unit.sv
tb/tb_csr_unit.sv

// ==== hw/csr_counters.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_counters (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               wren,
  input  wire csr_pkg::csr_addr_t waddr,
  input  wire csr_pkg::xlen_t     wdata,
  input  wire logic               retire,
  output csr_pkg::dword_t         mcycle,
  output csr_pkg::dword_t         minstret
);

  logic wr_cycle_lo;
  logic wr_cycle_hi;
  logic wr_instret_lo;
  logic wr_instret_hi;

  // a half write replaces that half and skips the increment
  function automatic csr_pkg::dword_t next_count(
    input csr_pkg::dword_t cur,
    input logic            wr_lo,
    input logic            wr_hi,
    input csr_pkg::xlen_t  data,
    input logic            inc
  );
    if (wr_lo) begin
      return {cur[63:32], data};
    end else if (wr_hi) begin
      return {data, cur[31:0]};
    end else if (inc) begin
      return cur + 64'd1;
    end
    return cur;
  endfunction

  assign wr_cycle_lo   = wren && (waddr == csr_pkg::csr_mcycle);
  assign wr_cycle_hi   = wren && (waddr == csr_pkg::csr_mcycleh);
  assign wr_instret_lo = wren && (waddr == csr_pkg::csr_minstret);
  assign wr_instret_hi = wren && (waddr == csr_pkg::csr_minstreth);

  always_ff @(posedge clk) begin
    if (!rst) begin
      mcycle   <= '0;
      minstret <= '0;
    end else begin
      mcycle   <= next_count(mcycle, wr_cycle_lo, wr_cycle_hi, wdata, 1'b1); // free running
      minstret <= next_count(minstret, wr_instret_lo, wr_instret_hi, wdata, retire);
    end
  end

endmodule

`default_nettype wire

// ==== hw/csr_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_file (
  input  wire logic               clk,
  input  wire logic               rst,
  // software write port
  input  wire logic               wren,
  input  wire csr_pkg::csr_addr_t waddr,
  input  wire csr_pkg::xlen_t     wdata,
  // software read port
  input  wire logic               rden,
  input  wire csr_pkg::csr_addr_t raddr,
  output csr_pkg::xlen_t          rdata,
  // trap and return
  input  wire logic               take_trap,
  input  wire logic               take_irq,
  input  wire csr_pkg::cause_t    take_cause,
  input  wire csr_pkg::xlen_t     epc,
  input  wire csr_pkg::xlen_t     tval,
  input  wire logic               mret_req,
  // floating point flags
  input  wire logic               fpu_valid,
  input  wire csr_pkg::fflags_t   fpu_fflags,
  // sampled pending bits
  input  wire logic               mip_meip,
  input  wire logic               mip_mtip,
  input  wire logic               mip_msip,
  // counters
  input  wire csr_pkg::dword_t    mcycle,
  input  wire csr_pkg::dword_t    minstret,
  // state towards trap logic and core
  output logic                    mstatus_mie,
  output logic                    mie_meie,
  output logic                    mie_mtie,
  output logic                    mie_msie,
  output csr_pkg::xlen_t          mtvec,
  output csr_pkg::xlen_t          mcause,
  output csr_pkg::xlen_t          mepc,
  output logic [1:0]              fs,
  output csr_pkg::frm_t           frm
);

  logic             mstatus_mpie;
  logic             mstatus_sd;
  csr_pkg::xlen_t   mscratch;
  csr_pkg::xlen_t   mtval;
  logic             mcause_irq;
  csr_pkg::cause_t  mcause_code;
  csr_pkg::fflags_t fflags;

  assign mstatus_sd = (fs == 2'b11); // dirty fp state summary
  assign mcause     = {mcause_irq, 27'b0, mcause_code};

  always_ff @(posedge clk) begin
    if (!rst) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b0;
      fs           <= 2'b00;
      mie_meie     <= 1'b0;
      mie_mtie     <= 1'b0;
      mie_msie     <= 1'b0;
      mtvec        <= csr_pkg::mtvec_reset;
      mscratch     <= '0;
      mepc         <= '0;
      mtval        <= '0;
      mcause_irq   <= 1'b0;
      mcause_code  <= '0;
      fflags       <= '0;
      frm          <= '0;
    end else begin
      if (wren) begin
        case (waddr)
          csr_pkg::csr_mstatus : begin
            fs           <= wdata[14:13];
            mstatus_mpie <= wdata[7];
            mstatus_mie  <= wdata[3];
          end
          csr_pkg::csr_mie : begin
            mie_meie <= wdata[11];
            mie_mtie <= wdata[7];
            mie_msie <= wdata[3];
          end
          csr_pkg::csr_mtvec    : mtvec <= {wdata[31:2], 1'b0, wdata[0]}; // mode 0 or 1 only
          csr_pkg::csr_mscratch : mscratch <= wdata;
          csr_pkg::csr_mepc     : mepc <= wdata;
          csr_pkg::csr_mtval    : mtval <= wdata;
          csr_pkg::csr_mcause : begin
            mcause_irq  <= wdata[31];
            mcause_code <= wdata[3:0];
          end
          csr_pkg::csr_fflags : fflags <= wdata[4:0];
          csr_pkg::csr_frm    : frm <= wdata[2:0];
          csr_pkg::csr_fcsr : begin
            frm    <= wdata[7:5];
            fflags <= wdata[4:0];
          end
          default : ;
        endcase
      end

      // hardware updates come last so they override a software write
      if (fpu_valid) begin
        fflags <= fpu_fflags;
      end

      if (mret_req) begin
        mstatus_mie  <= mstatus_mpie;
        mstatus_mpie <= 1'b0;
      end

      if (take_trap) begin
        mstatus_mpie <= mstatus_mie; // stack the enable
        mstatus_mie  <= 1'b0;
        mepc         <= epc;
        mtval        <= tval;
        mcause_irq   <= take_irq;
        mcause_code  <= take_cause;
      end
    end
  end

  always_comb begin
    rdata = '0;
    if (rden) begin
      case (raddr)
        csr_pkg::csr_mstatus : rdata = {mstatus_sd, 16'b0, fs, 5'b0,
                                        mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
        csr_pkg::csr_misa    : rdata = csr_pkg::misa_value;
        csr_pkg::csr_mie     : rdata = {20'b0, mie_meie, 3'b0, mie_mtie, 3'b0,
                                        mie_msie, 3'b0};
        csr_pkg::csr_mip     : rdata = {20'b0, mip_meip, 3'b0, mip_mtip, 3'b0,
                                        mip_msip, 3'b0};
        csr_pkg::csr_mtvec     : rdata = mtvec;
        csr_pkg::csr_mscratch  : rdata = mscratch;
        csr_pkg::csr_mepc      : rdata = mepc;
        csr_pkg::csr_mcause    : rdata = mcause;
        csr_pkg::csr_mtval     : rdata = mtval;
        csr_pkg::csr_mcycle    : rdata = mcycle[31:0];
        csr_pkg::csr_mcycleh   : rdata = mcycle[63:32];
        csr_pkg::csr_minstret  : rdata = minstret[31:0];
        csr_pkg::csr_minstreth : rdata = minstret[63:32];
        csr_pkg::csr_fflags    : rdata = {27'b0, fflags};
        csr_pkg::csr_frm       : rdata = {29'b0, frm};
        csr_pkg::csr_fcsr      : rdata = {24'b0, frm, fflags};
        default                : rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

  // widths with a meaning of their own
  typedef logic [31:0] xlen_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [3:0]  cause_t;    // exception or interrupt code
  typedef logic [4:0]  fflags_t;   // nv dz of uf nx
  typedef logic [2:0]  frm_t;
  typedef logic [63:0] dword_t;

  // floating point user registers
  localparam csr_addr_t csr_fflags    = 12'h001;
  localparam csr_addr_t csr_frm       = 12'h002;
  localparam csr_addr_t csr_fcsr      = 12'h003;

  // machine trap setup
  localparam csr_addr_t csr_mstatus   = 12'h300;
  localparam csr_addr_t csr_misa      = 12'h301;
  localparam csr_addr_t csr_mie       = 12'h304;
  localparam csr_addr_t csr_mtvec     = 12'h305;

  // machine trap handling
  localparam csr_addr_t csr_mscratch  = 12'h340;
  localparam csr_addr_t csr_mepc      = 12'h341;
  localparam csr_addr_t csr_mcause    = 12'h342;
  localparam csr_addr_t csr_mtval     = 12'h343;
  localparam csr_addr_t csr_mip       = 12'h344;

  // machine counters, low and high halves
  localparam csr_addr_t csr_mcycle    = 12'hb00;
  localparam csr_addr_t csr_minstret  = 12'hb02;
  localparam csr_addr_t csr_mcycleh   = 12'hb80;
  localparam csr_addr_t csr_minstreth = 12'hb82;

  // machine interrupt codes, also the mip/mie bit positions
  localparam cause_t irq_mach_soft   = 4'd3;
  localparam cause_t irq_mach_timer  = 4'd7;
  localparam cause_t irq_mach_extern = 4'd11;

  // mxl = 1 (rv32), extensions f, i, m
  localparam xlen_t misa_value = {2'b01, 4'b0000, 26'b00_0000_0000_0001_0001_0010_0000};

  // direct mode, base at 0x100
  localparam xlen_t mtvec_reset = 32'h0000_0100;

endpackage

`default_nettype wire

// ==== hw/csr_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_unit (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               rden,
  input  wire csr_pkg::csr_addr_t raddr,
  output csr_pkg::xlen_t          rdata,
  input  wire logic               wren,
  input  wire csr_pkg::csr_addr_t waddr,
  input  wire csr_pkg::xlen_t     wdata,
  input  wire logic               retire,
  input  wire logic               exc_valid,
  input  wire csr_pkg::cause_t    exc_cause,
  input  wire csr_pkg::xlen_t     epc,
  input  wire csr_pkg::xlen_t     tval,
  input  wire logic               mret_req,
  input  wire logic               fpu_valid,
  input  wire csr_pkg::fflags_t   fpu_fflags,
  input  wire logic               meip,
  input  wire logic               mtip,
  input  wire logic               msip,
  output logic                    trap,
  output logic                    mret,
  output csr_pkg::xlen_t          trap_vector,
  output csr_pkg::xlen_t          mepc,
  output logic [1:0]              fs,
  output csr_pkg::frm_t           frm
);

  logic            mstatus_mie;
  logic            mie_meie;
  logic            mie_mtie;
  logic            mie_msie;
  csr_pkg::xlen_t  mtvec;
  csr_pkg::xlen_t  mcause;
  logic            take_trap;
  logic            take_irq;
  csr_pkg::cause_t take_cause;
  logic            mip_meip;
  logic            mip_mtip;
  logic            mip_msip;
  csr_pkg::dword_t mcycle;
  csr_pkg::dword_t minstret;

  csr_file u_file (
    .clk, .rst,
    .wren, .waddr, .wdata,
    .rden, .raddr, .rdata,
    .take_trap, .take_irq, .take_cause, .epc, .tval, .mret_req,
    .fpu_valid, .fpu_fflags,
    .mip_meip, .mip_mtip, .mip_msip,
    .mcycle, .minstret,
    .mstatus_mie, .mie_meie, .mie_mtie, .mie_msie,
    .mtvec, .mcause, .mepc, .fs, .frm
  );

  csr_counters u_counters (
    .clk, .rst,
    .wren, .waddr, .wdata,
    .retire,
    .mcycle, .minstret
  );

  trap_unit u_trap (
    .clk, .rst,
    .meip, .mtip, .msip,
    .mstatus_mie, .mie_meie, .mie_mtie, .mie_msie,
    .retire, .exc_valid, .exc_cause, .mret_req,
    .mtvec, .mcause,
    .take_trap, .take_irq, .take_cause,
    .mip_meip, .mip_mtip, .mip_msip,
    .trap, .mret, .trap_vector
  );

endmodule

`default_nettype wire

// ==== hw/trap_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module trap_unit (
  input  wire logic            clk,
  input  wire logic            rst,
  // interrupt pins and enables
  input  wire logic            meip,
  input  wire logic            mtip,
  input  wire logic            msip,
  input  wire logic            mstatus_mie,
  input  wire logic            mie_meie,
  input  wire logic            mie_mtie,
  input  wire logic            mie_msie,
  // requests from the core
  input  wire logic            retire,
  input  wire logic            exc_valid,
  input  wire csr_pkg::cause_t exc_cause,
  input  wire logic            mret_req,
  // vector base and current cause
  input  wire csr_pkg::xlen_t  mtvec,
  input  wire csr_pkg::xlen_t  mcause,
  // towards the register file
  output logic                 take_trap,
  output logic                 take_irq,
  output csr_pkg::cause_t      take_cause,
  output logic                 mip_meip,
  output logic                 mip_mtip,
  output logic                 mip_msip,
  // towards the core
  output logic                 trap,
  output logic                 mret,
  output csr_pkg::xlen_t       trap_vector
);

  logic ext_ready;
  logic tmr_ready;
  logic sft_ready;
  logic irq_ready;

  // pins are sampled once, so mip lags them by a cycle
  always_ff @(posedge clk) begin
    if (!rst) begin
      mip_meip <= 1'b0;
      mip_mtip <= 1'b0;
      mip_msip <= 1'b0;
    end else begin
      mip_meip <= meip;
      mip_mtip <= mtip;
      mip_msip <= msip;
    end
  end

  assign ext_ready = mip_meip && mie_meie;
  assign tmr_ready = mip_mtip && mie_mtie;
  assign sft_ready = mip_msip && mie_msie;

  // interrupts are only taken at an instruction boundary
  assign irq_ready = mstatus_mie && retire && (ext_ready || tmr_ready || sft_ready);

  assign take_trap = exc_valid || irq_ready;
  assign take_irq  = !exc_valid;

  always_comb begin
    if (exc_valid) begin
      take_cause = exc_cause;
    end else if (ext_ready) begin
      take_cause = csr_pkg::irq_mach_extern;
    end else if (tmr_ready) begin
      take_cause = csr_pkg::irq_mach_timer;
    end else begin
      take_cause = csr_pkg::irq_mach_soft;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      trap <= 1'b0;
      mret <= 1'b0;
    end else begin
      trap <= take_trap;
      mret <= mret_req;
    end
  end

  // vectored mode (1) adds 4 * cause to the base
  always_comb begin
    if (mtvec[1:0] == 2'b01) begin
      trap_vector = {mtvec[31:2] + {26'b0, mcause[3:0]}, 2'b00};
    end else begin
      trap_vector = {mtvec[31:2], 2'b00};
    end
  end

endmodule

`default_nettype wire

// ==== tb/csr_tests.svh ====
// each row holds the operation, the csr address (the cause for exceptions), the data
// and the expected value; data is the epc for exceptions, {meip, mtip, msip} for
// interrupt steps and a cycle count for idle and retire rows
// expected is the trap vector for exceptions and the trap level for interrupt steps

task automatic push_row(input int op, input csr_pkg::csr_addr_t addr,
                        input csr_pkg::xlen_t data, input csr_pkg::xlen_t expected);
  op_q.push_back(op);
  addr_q.push_back(addr);
  data_q.push_back(data);
  exp_q.push_back(expected);
endtask

task automatic build_table();
  csr_pkg::xlen_t d, r, b, v, h;
  push_row(op_rd, csr_pkg::csr_mtvec, 0, csr_pkg::mtvec_reset);
  push_row(op_rd, csr_pkg::csr_misa, 0, csr_pkg::misa_value);
  push_row(op_rd, csr_pkg::csr_mstatus, 0, 0);
  d = $random(seed);
  push_row(op_wr, csr_pkg::csr_mscratch, d, 0);
  push_row(op_rd, csr_pkg::csr_mscratch, 0, d);
  d = $random(seed);
  push_row(op_wr, csr_pkg::csr_mtvec, d, 0);
  push_row(op_rd, csr_pkg::csr_mtvec, 0, d & 32'hffff_fffd); // only modes 0 and 1
  d = $random(seed);
  push_row(op_wr, csr_pkg::csr_mie, d, 0);
  push_row(op_rd, csr_pkg::csr_mie, 0, d & 32'h0000_0888);
  d = $random(seed);
  push_row(op_wr, csr_pkg::csr_mstatus, d, 0);
  push_row(op_rd, csr_pkg::csr_mstatus, 0, (d & 32'h0000_6088) | {&d[14:13], 31'b0});
  push_row(op_wr, csr_pkg::csr_misa, d, 0);
  push_row(op_rd, csr_pkg::csr_misa, 0, csr_pkg::misa_value);
  // fcsr is frm and fflags side by side
  d = $random(seed);
  r = $random(seed);
  push_row(op_wr, csr_pkg::csr_fcsr, d, 0);
  push_row(op_rd, csr_pkg::csr_frm, 0, d[7:5]);
  push_row(op_rd, csr_pkg::csr_fflags, 0, d[4:0]);
  push_row(op_wr, csr_pkg::csr_frm, r, 0);
  push_row(op_rd, csr_pkg::csr_fcsr, 0, {r[2:0], d[4:0]});
  // exception in direct mode
  b = $random(seed) & 32'hffff_ff00;
  d = $random(seed);
  push_row(op_wr, csr_pkg::csr_mtvec, b, 0);
  push_row(op_wr, csr_pkg::csr_mstatus, 32'h8, 0);
  push_row(op_exc, 12'd2, d, b);
  push_row(op_rd, csr_pkg::csr_mepc, 0, d);
  push_row(op_rd, csr_pkg::csr_mtval, 0, ~d);
  push_row(op_rd, csr_pkg::csr_mcause, 0, 32'd2);
  push_row(op_rd, csr_pkg::csr_mstatus, 0, 32'h80); // mpie set, mie clear
  // vectored mode, then return
  d = $random(seed);
  push_row(op_wr, csr_pkg::csr_mtvec, b | 32'h1, 0);
  push_row(op_wr, csr_pkg::csr_mstatus, 32'h8, 0);
  push_row(op_exc, 12'd5, d, b + 4 * 5);
  push_row(op_rd, csr_pkg::csr_mcause, 0, 32'd5);
  push_row(op_mret, 0, 0, 0);
  push_row(op_rd, csr_pkg::csr_mstatus, 0, 32'h8);
  // interrupt priority, external over timer over software
  push_row(op_wr, csr_pkg::csr_mie, 32'h888, 0);
  push_row(op_irq, 0, 3'b111, 1);
  push_row(op_rd, csr_pkg::csr_mip, 0, 32'h888);
  push_row(op_rd, csr_pkg::csr_mcause, 0, 32'h8000_0000 | csr_pkg::irq_mach_extern);
  push_row(op_wr, csr_pkg::csr_mie, 32'h088, 0);
  push_row(op_wr, csr_pkg::csr_mstatus, 32'h8, 0);
  push_row(op_irq, 0, 3'b111, 1);
  push_row(op_rd, csr_pkg::csr_mcause, 0, 32'h8000_0000 | csr_pkg::irq_mach_timer);
  push_row(op_wr, csr_pkg::csr_mie, 32'h008, 0);
  push_row(op_wr, csr_pkg::csr_mstatus, 32'h8, 0);
  push_row(op_irq, 0, 3'b111, 1);
  push_row(op_rd, csr_pkg::csr_mcause, 0, 32'h8000_0000 | csr_pkg::irq_mach_soft);
  push_row(op_wr, csr_pkg::csr_mie, 32'h888, 0);
  push_row(op_irq, 0, 3'b111, 0); // mstatus.mie still clear from the last trap
  push_row(op_rd, csr_pkg::csr_mcause, 0, 32'h8000_0000 | csr_pkg::irq_mach_soft);
  push_row(op_irq, 0, 3'b000, 0);
  // counters
  v = $random(seed);
  push_row(op_wr, csr_pkg::csr_mcycle, v, 0);
  push_row(op_idle, 0, 3, 0);
  push_row(op_rd, csr_pkg::csr_mcycle, 0, v + 3);
  h = $random(seed);
  push_row(op_wr, csr_pkg::csr_mcycleh, h, 0);
  push_row(op_rd, csr_pkg::csr_mcycleh, 0, h);
  v = $random(seed);
  h = $random(seed);
  push_row(op_wr, csr_pkg::csr_minstret, v, 0);
  push_row(op_wr, csr_pkg::csr_minstreth, h, 0);
  push_row(op_rd, csr_pkg::csr_minstreth, 0, h);
  push_row(op_rd, csr_pkg::csr_minstret, 0, v);
  push_row(op_ret, 0, 5, 0);
  push_row(op_rd, csr_pkg::csr_minstret, 0, v + 5);
  // flags from the fpu
  d = $random(seed);
  push_row(op_fpu, 0, d, 0);
  push_row(op_rd, csr_pkg::csr_fflags, 0, d[4:0]);
  push_row(op_rd, csr_pkg::csr_fcsr, 0, {r[2:0], d[4:0]});
endtask

// ==== tb/tb_csr_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_csr_unit;

  localparam int clk_period = 100;

  // row operations
  localparam int op_wr   = 0;
  localparam int op_rd   = 1;
  localparam int op_exc  = 2;
  localparam int op_irq  = 3;
  localparam int op_mret = 4;
  localparam int op_ret  = 5;
  localparam int op_idle = 6;
  localparam int op_fpu  = 7;

  logic clk, rst, rden, wren, retire, exc_valid, mret_req, fpu_valid;
  logic meip, mtip, msip, trap, mret;
  logic [1:0] fs;
  csr_pkg::csr_addr_t raddr, waddr;
  csr_pkg::xlen_t rdata, wdata, epc, tval, trap_vector, mepc;
  csr_pkg::cause_t exc_cause;
  csr_pkg::fflags_t fpu_fflags;
  csr_pkg::frm_t frm;

  integer seed = 2585;
  logic table_ready = 1'b0;
  int op_q[$];
  csr_pkg::csr_addr_t addr_q[$];
  csr_pkg::xlen_t data_q[$];
  csr_pkg::xlen_t exp_q[$];

  csr_unit uut (.*);

  `include "csr_tests.svh"

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic check(input csr_pkg::xlen_t actual, input csr_pkg::xlen_t expected,
                       input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("Verification failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // inputs change a little after the rising edge
  task automatic next_slot();
    @(posedge clk);
    #10;
  endtask

  task automatic apply_row(input int i);
    int op;
    csr_pkg::csr_addr_t a;
    csr_pkg::xlen_t d;
    csr_pkg::xlen_t x;
    op = op_q[i];
    a = addr_q[i];
    d = data_q[i];
    x = exp_q[i];
    case (op)
      op_wr: begin
        wren = 1'b1;
        waddr = a;
        wdata = d;
        next_slot();
        wren = 1'b0;
      end
      op_rd: begin
        rden = 1'b1;
        raddr = a;
        #40; // falling edge
        check(rdata, x, $sformatf("row %0d read of csr %h", i, a));
        case (a)
          csr_pkg::csr_mstatus : check(fs, x[14:13], "fs port");
          csr_pkg::csr_frm     : check(frm, x[2:0], "frm port");
          csr_pkg::csr_fcsr    : check(frm, x[7:5], "frm port");
          default              : ;
        endcase
        next_slot();
        rden = 1'b0;
      end
      op_exc: begin
        exc_valid = 1'b1;
        exc_cause = a[3:0];
        epc = d;
        tval = ~d;
        next_slot();
        exc_valid = 1'b0;
        #40;
        check(trap, 32'd1, "trap pulse after exception");
        check(mepc, d, "mepc port");
        check(trap_vector, x, "trap vector");
        next_slot();
      end
      op_irq: begin
        meip = d[2];
        mtip = d[1];
        msip = d[0];
        next_slot(); // pins reach mip
        retire = 1'b1;
        next_slot();
        retire = 1'b0;
        #40;
        check(trap, x, $sformatf("row %0d trap after interrupt step", i));
        next_slot();
      end
      op_mret: begin
        mret_req = 1'b1;
        next_slot();
        mret_req = 1'b0;
        #40;
        check(mret, 32'd1, "mret pulse");
        next_slot();
      end
      op_ret: begin
        retire = 1'b1;
        repeat (d) next_slot();
        retire = 1'b0;
      end
      op_idle: repeat (d) next_slot();
      op_fpu: begin
        fpu_valid = 1'b1;
        fpu_fflags = d[4:0];
        next_slot();
        fpu_valid = 1'b0;
      end
      default: begin
        $display("unknown operation %0d in test row %0d", op, i);
        $display("Verification failed");
        $fatal(1, "bad test table");
      end
    endcase
  endtask

  initial begin
    wait (table_ready === 1'b1);
    #((op_q.size() * 4 + 20) * clk_period);
    $display("timeout: the test table did not complete in time");
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst = 1'b0;
    rden = 1'b0;
    wren = 1'b0;
    raddr = '0;
    waddr = '0;
    wdata = '0;
    retire = 1'b0;
    exc_valid = 1'b0;
    exc_cause = '0;
    epc = '0;
    tval = '0;
    mret_req = 1'b0;
    fpu_valid = 1'b0;
    fpu_fflags = '0;
    meip = 1'b0;
    mtip = 1'b0;
    msip = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    #10;
    rst = 1'b1;
    for (int i = 0; i < op_q.size(); i++) begin
      apply_row(i);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
